// ==== vlog.f ====
+incdir+include
design/plotter_pkg.sv
design/move_sequencer.sv
design/pen_position_tracker.sv
design/canvas_writer.sv
design/plotter_top.sv
bench/plotter_clock_gen.sv
bench/plotter_props.sv
bench/plotter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= plotter_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/plotter_tb.sv ====
`timescale 1ns/1ns
`include "plotter_defines.svh"

module plotter_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int XB           = `PLOT_CANVAS_X_BITS;
	localparam int YB           = `PLOT_CANVAS_Y_BITS;
	localparam int MB           = `PLOT_MOVE_BITS;
	localparam int COLS         = 1 << XB;
	localparam int ROWS         = 1 << YB;
	localparam int RANDOM_CMDS  = 48;

	// one scheduled command, overlap means it is strobed while the previous move runs
	typedef struct packed {
		plotter_pkg::plot_cmd_t cmd;
		logic                   overlap;
		logic                   check;
	} cmd_entry_t;

	logic                       clk;
	logic                       reset;
	plotter_pkg::plot_cmd_t     cmd;
	logic                       cmd_valid;
	logic                       busy;
	logic [XB-1:0]              rd_x;
	logic [YB-1:0]              rd_y;
	logic [`PLOT_INK_BITS-1:0]  rd_data;

	// model of the picture and of the pen
	logic [`PLOT_INK_BITS-1:0]  model_canvas [COLS][ROWS];
	int                         model_x;
	int                         model_y;
	logic                       model_pen;

	cmd_entry_t                 plan_q [$];
	logic                       check_req;
	logic                       check_ack;
	logic                       budget_ready;
	longint                     budget_ns;

	plotter_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
		.clk   (clk),
		.reset (reset)
	);

	plotter_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.busy      (busy),
		.rd_x      (rd_x),
		.rd_y      (rd_y),
		.rd_data   (rd_data)
	);

	bind move_sequencer plotter_props u_props (
		.clk   (clk),
		.reset (reset),
		.busy  (busy),
		.steps (steps)
	);

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	function automatic int offset_abs(input logic signed [MB-1:0] v);
		int value;
		value = int'(v);
		return (value < 0) ? -value : value;
	endfunction

	function automatic void mark_pen_cell();
		model_canvas[model_x][model_y] = `PLOT_INK;
	endfunction

	// expected effect of one accepted command, X is walked pixel by pixel before Y
	function automatic void apply_command(input plotter_pkg::plot_cmd_t c);
		int step_x;
		int step_y;
		step_x = (c.dx < 0) ? -1 : 1;
		step_y = (c.dy < 0) ? -1 : 1;
		case (c.op)
			plotter_pkg::PEN_UP: model_pen = 1'b0;
			plotter_pkg::PEN_DOWN: begin
				model_pen = 1'b1;
				mark_pen_cell();
			end
			plotter_pkg::MOVE: begin
				for (int i = 0; i < offset_abs(c.dx); i++) begin
					model_x = (model_x + step_x + COLS) % COLS;
					if (model_pen) mark_pen_cell();
				end
				for (int i = 0; i < offset_abs(c.dy); i++) begin
					model_y = (model_y + step_y + ROWS) % ROWS;
					if (model_pen) mark_pen_cell();
				end
			end
			default: ;
		endcase
	endfunction

	function automatic void queue_command(input plotter_pkg::opcode_t op, input int dx,
		input int dy, input logic overlap, input logic check);
		cmd_entry_t e;
		e.cmd.op  = op;
		e.cmd.dx  = MB'(dx);
		e.cmd.dy  = MB'(dy);
		e.overlap = overlap;
		e.check   = check;
		plan_q.push_back(e);
	endfunction

	function automatic void build_directed();
		// pen raised, one move per direction, then lowering marks only (5,4)
		queue_command(plotter_pkg::MOVE, 9, 0, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, -4, 0, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, 0, 6, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, 0, -2, 1'b0, 1'b1);
		queue_command(plotter_pkg::PEN_DOWN, 0, 0, 1'b0, 1'b1);
		// an L from (5,4) to (11,9)
		queue_command(plotter_pkg::MOVE, 6, 5, 1'b0, 1'b1);
		// wrap past the left, bottom, right and top edges
		queue_command(plotter_pkg::PEN_UP, 0, 0, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, -8, 0, 1'b0, 1'b0);
		queue_command(plotter_pkg::PEN_DOWN, 0, 0, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, -6, 10, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, 8, -7, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, -32, 0, 1'b0, 1'b1);
		// strobes that land while a move runs must be dropped
		queue_command(plotter_pkg::MOVE, 4, 3, 1'b0, 1'b0);
		queue_command(plotter_pkg::MOVE, 5, 3, 1'b1, 1'b0);
		queue_command(plotter_pkg::MOVE, -5, 2, 1'b0, 1'b0);
		queue_command(plotter_pkg::PEN_UP, 0, 0, 1'b1, 1'b0);
		queue_command(plotter_pkg::MOVE, 3, 0, 1'b0, 1'b1);
	endfunction

	function automatic void build_random();
		int pick;
		plotter_pkg::opcode_t op;
		for (int i = 0; i < RANDOM_CMDS; i++) begin
			pick = int'($urandom % 8);
			if (pick < 2) op = plotter_pkg::PEN_UP;
			else if (pick < 4) op = plotter_pkg::PEN_DOWN;
			else op = plotter_pkg::MOVE;
			queue_command(op, int'($urandom % 64), int'($urandom % 64), 1'b0,
				((i % 12) == 11));
		end
	endfunction

	// cycles needed for every pulse, the per command waits and all readbacks
	function automatic longint run_budget();
		longint cycles;
		cycles = RESET_CYCLES + 200 + (COLS * ROWS + 8);
		foreach (plan_q[i]) begin
			cycles += 16;
			if (plan_q[i].cmd.op == plotter_pkg::MOVE) begin
				cycles += (offset_abs(plan_q[i].cmd.dx) + offset_abs(plan_q[i].cmd.dy))
					* `PLOT_PULSES_PER_PIXEL * 2 * `PLOT_PULSE_HALF;
			end
			if (plan_q[i].check) cycles += COLS * ROWS + 8;
		end
		return cycles;
	endfunction

	// strobe for one cycle, returns on the next falling edge
	task automatic strobe_cmd(input plotter_pkg::plot_cmd_t c);
		cmd       = c;
		cmd_valid = 1'b1;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy) @(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic request_readback();
		check_req = 1'b1;
		wait (check_ack);
		check_req = 1'b0;
		wait (!check_ack);
	endtask

	// each address is set on a falling edge and its data sampled on the next one
	task automatic compare_canvas();
		for (int cx = 0; cx < COLS; cx++) begin
			for (int cy = 0; cy < ROWS; cy++) begin
				rd_x = XB'(cx);
				rd_y = YB'(cy);
				@(negedge clk);
				assert (rd_data === model_canvas[cx][cy])
					else report_failure($sformatf("FAILED at %0t: cell (%0d,%0d) expected %02h, read %02h",
						$time, cx, cy, model_canvas[cx][cy], rd_data));
			end
		end
	endtask

	initial begin : readback
		check_ack = 1'b0;
		forever begin
			wait (check_req);
			compare_canvas();
			check_ack = 1'b1;
			wait (!check_req);
			check_ack = 1'b0;
		end
	end

	initial begin : watchdog
		wait (budget_ready);
		#(budget_ns);
		report_failure("the run took longer than its time budget, the plotter seems to hang");
	end

	initial begin : stimulus
		cmd_entry_t e;
		logic       next_overlap;
		cmd          = '0;
		cmd_valid    = 1'b0;
		rd_x         = '0;
		rd_y         = '0;
		check_req    = 1'b0;
		budget_ready = 1'b0;
		model_x      = 0;
		model_y      = 0;
		model_pen    = 1'b0;
		for (int cx = 0; cx < COLS; cx++) begin
			for (int cy = 0; cy < ROWS; cy++) begin
				model_canvas[cx][cy] = '0;
			end
		end
		void'($urandom(32'h1dd0));
		build_directed();
		build_random();
		budget_ns    = run_budget() * CLK_PERIOD;
		budget_ready = 1'b1;
		wait (!reset);
		@(negedge clk);
		// a freshly reset canvas is blank
		request_readback();
		for (int i = 0; i < plan_q.size(); i++) begin
			e = plan_q[i];
			if (e.overlap) begin
				assert (busy)
					else report_failure("the overlapping command found the plotter idle");
			end
			strobe_cmd(e.cmd);
			if (!e.overlap) apply_command(e.cmd);
			next_overlap = 1'b0;
			if (i + 1 < plan_q.size()) next_overlap = plan_q[i + 1].overlap;
			if (!next_overlap) wait_idle();
			if (e.check) request_readback();
		end
		request_readback();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== bench/plotter_props.sv ====
`timescale 1ns/1ns

module plotter_props (
	input logic                   clk,
	input logic                   reset,
	input logic                   busy,
	input plotter_pkg::step_bus_t steps
);

	// the sequencer finishes X before it starts Y, so both lines never pulse at once
	a_one_axis: assert property (@(posedge clk) disable iff (reset)
		!(steps.step_x && steps.step_y))
		else $error("step_x and step_y are high in the same cycle");

	// a direction level must already be settled in the cycle a pulse rises and stay put
	a_dir_x_hold: assert property (@(posedge clk) disable iff (reset)
		steps.step_x |-> $stable(steps.dir_x))
		else $error("dir_x changed while step_x was high");

	a_dir_y_hold: assert property (@(posedge clk) disable iff (reset)
		steps.step_y |-> $stable(steps.dir_y))
		else $error("dir_y changed while step_y was high");

	// reset leaves the sequencer idle
	a_idle_after_reset: assert property (@(posedge clk)
		$past(reset) |-> !busy)
		else $error("busy is high right after reset");

	// pulses only come out while a move is in progress
	a_no_idle_pulse: assert property (@(posedge clk) disable iff (reset)
		!busy |-> !(steps.step_x || steps.step_y))
		else $error("a step pulse appeared while busy was low");

endmodule

// ==== bench/plotter_clock_gen.sv ====
`timescale 1ns/1ns

module plotter_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	// free running clock, the first rising edge comes half a period in
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset is held for the given number of rising edges and dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== design/plotter_top.sv ====
`timescale 1ns/1ns
`include "plotter_defines.svh"

module plotter_top (
	input  logic                              clk,
	input  logic                              reset,
	input  plotter_pkg::plot_cmd_t            cmd,
	input  logic                              cmd_valid,
	output logic                              busy,
	input  logic [`PLOT_CANVAS_X_BITS-1:0]    rd_x,
	input  logic [`PLOT_CANVAS_Y_BITS-1:0]    rd_y,
	output logic [`PLOT_INK_BITS-1:0]         rd_data
);

	// stepper lines from the sequencer to the tracker
	plotter_pkg::step_bus_t    steps;
	// pen pixel and ink from the tracker to the canvas
	plotter_pkg::pixel_write_t pixel;

	move_sequencer u_seq (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.busy      (busy),
		.steps     (steps)
	);

	pen_position_tracker u_tracker (
		.clk   (clk),
		.reset (reset),
		.steps (steps),
		.pixel (pixel)
	);

	canvas_writer u_canvas (
		.clk     (clk),
		.reset   (reset),
		.pixel   (pixel),
		.rd_x    (rd_x),
		.rd_y    (rd_y),
		.rd_data (rd_data)
	);

endmodule

// ==== design/canvas_writer.sv ====
`timescale 1ns/1ns
`include "plotter_defines.svh"

module canvas_writer (
	input  logic                              clk,
	input  logic                              reset,
	input  plotter_pkg::pixel_write_t         pixel,
	input  logic [`PLOT_CANVAS_X_BITS-1:0]    rd_x,
	input  logic [`PLOT_CANVAS_Y_BITS-1:0]    rd_y,
	output logic [`PLOT_INK_BITS-1:0]         rd_data
);

	localparam int COLS = 1 << `PLOT_CANVAS_X_BITS;
	localparam int ROWS = 1 << `PLOT_CANVAS_Y_BITS;

	// the canvas is a plain register array indexed by column and then row
	logic [`PLOT_INK_BITS-1:0] canvas [COLS][ROWS];

	// reset wipes the picture, otherwise the pen cell is written every cycle it is down
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int cx = 0; cx < COLS; cx++) begin
				for (int cy = 0; cy < ROWS; cy++) begin
					canvas[cx][cy] <= '0;
				end
			end
		end else if (pixel.wr_en) begin
			canvas[pixel.x][pixel.y] <= pixel.ink;
		end
	end

	// readback is one cycle behind the address
	always_ff @(posedge clk) begin
		rd_data <= canvas[rd_x][rd_y];
	end

endmodule

// ==== design/pen_position_tracker.sv ====
`timescale 1ns/1ns
`include "plotter_defines.svh"

module pen_position_tracker (
	input  logic                       clk,
	input  logic                       reset,
	input  plotter_pkg::step_bus_t     steps,
	output plotter_pkg::pixel_write_t  pixel
);

	localparam int CNT_BITS = $clog2(`PLOT_PULSES_PER_PIXEL) + 1;
	localparam logic [CNT_BITS-1:0] LAST_EDGE = CNT_BITS'(`PLOT_PULSES_PER_PIXEL - 1);

	// index 0 is the X axis and index 1 is the Y axis
	logic [1:0]                           step_now;
	logic [1:0]                           dir_now;
	logic [1:0]                           prev;
	logic [1:0]                           rise;
	logic [1:0][CNT_BITS-1:0]             edge_cnt;
	logic [1:0][`PLOT_POS_BITS-1:0]       pos;

	assign step_now = {steps.step_y, steps.step_x};
	assign dir_now  = {steps.dir_y, steps.dir_x};

	// a rising edge is a high step line against a low registered level
	assign rise = step_now & ~prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			// take the live levels so that leaving reset is not seen as an edge
			prev     <= step_now;
			edge_cnt <= '0;
			pos      <= '0;
		end else begin
			prev <= step_now;
			for (int a = 0; a < 2; a++) begin
				if (rise[a]) begin
					if (edge_cnt[a] == LAST_EDGE) begin
						// a full pixel worth of edges, step the pen one pixel
						edge_cnt[a] <= '0;
						pos[a]      <= dir_now[a] ? (pos[a] - 1'b1) : (pos[a] + 1'b1);
					end else begin
						edge_cnt[a] <= edge_cnt[a] + 1'b1;
					end
				end
			end
		end
	end

	// the canvas address is the low position bits, so moves wrap at the edges
	always_comb begin
		pixel.wr_en = steps.pen_down;
		pixel.x     = pos[0][`PLOT_CANVAS_X_BITS-1:0];
		pixel.y     = pos[1][`PLOT_CANVAS_Y_BITS-1:0];
		pixel.ink   = `PLOT_INK;
	end

endmodule

// ==== design/move_sequencer.sv ====
`timescale 1ns/1ns
`include "plotter_defines.svh"

module move_sequencer (
	input  logic                    clk,
	input  logic                    reset,
	input  plotter_pkg::plot_cmd_t  cmd,
	input  logic                    cmd_valid,
	output logic                    busy,
	output plotter_pkg::step_bus_t  steps
);

	// pulse counts go up to 32 pixels times the pulses per pixel
	localparam int CNT_BITS = `PLOT_MOVE_BITS + $clog2(`PLOT_PULSES_PER_PIXEL);
	localparam int TMR_BITS = $clog2(`PLOT_PULSE_HALF + 1);
	localparam logic [TMR_BITS-1:0] HALF_LOAD = TMR_BITS'(`PLOT_PULSE_HALF - 1);

	plotter_pkg::seq_state_t state;

	// pulses of the current axis that have not started yet
	logic [CNT_BITS-1:0] remaining;
	// Y pulses parked here while the X axis runs
	logic [CNT_BITS-1:0] y_pulses;
	logic [TMR_BITS-1:0] timer;
	logic                level;
	logic                pen;
	logic                dir_x;
	logic                dir_y;
	logic                accept;
	logic [CNT_BITS-1:0] load_x;
	logic [CNT_BITS-1:0] load_y;

	// magnitude of a signed offset, -32 comes out as 32 in the unsigned result
	function automatic logic [`PLOT_MOVE_BITS-1:0] magnitude(
		input logic signed [`PLOT_MOVE_BITS-1:0] v
	);
		return v[`PLOT_MOVE_BITS-1] ? -v : v;
	endfunction

	// number of step pulses that move the pen by the given offset
	function automatic logic [CNT_BITS-1:0] pulse_count(
		input logic signed [`PLOT_MOVE_BITS-1:0] v
	);
		return CNT_BITS'(magnitude(v)) * CNT_BITS'(`PLOT_PULSES_PER_PIXEL);
	endfunction

	// commands are only taken while idle, a strobe during a move is dropped
	assign accept = cmd_valid && (state == plotter_pkg::IDLE);
	assign load_x = pulse_count(cmd.dx);
	assign load_y = pulse_count(cmd.dy);
	assign busy   = (state != plotter_pkg::IDLE);

	// step lines come straight from the state and the pulse level
	always_comb begin
		steps.step_x   = (state == plotter_pkg::STEP_X) && level;
		steps.dir_x    = dir_x;
		steps.step_y   = (state == plotter_pkg::STEP_Y) && level;
		steps.dir_y    = dir_y;
		steps.pen_down = pen;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= plotter_pkg::IDLE;
			remaining <= '0;
			y_pulses  <= '0;
			timer     <= '0;
			level     <= 1'b0;
			pen       <= 1'b0;
			dir_x     <= 1'b0;
			dir_y     <= 1'b0;
		end else begin
			unique case (state)
				plotter_pkg::IDLE: begin
					if (accept) begin
						case (cmd.op)
							plotter_pkg::PEN_UP:   pen <= 1'b0;
							plotter_pkg::PEN_DOWN: pen <= 1'b1;
							plotter_pkg::MOVE: begin
								// a zero move leaves everything alone and busy stays low
								if ((load_x != '0) || (load_y != '0)) begin
									// both directions settle here and hold for the whole move
									dir_x    <= cmd.dx[`PLOT_MOVE_BITS-1];
									dir_y    <= cmd.dy[`PLOT_MOVE_BITS-1];
									y_pulses <= load_y;
									level    <= 1'b0;
									timer    <= '0;
									if (load_x != '0) begin
										state     <= plotter_pkg::STEP_X;
										remaining <= load_x;
									end else begin
										state     <= plotter_pkg::STEP_Y;
										remaining <= load_y;
									end
								end
							end
							default: ;
						endcase
					end
				end
				plotter_pkg::STEP_X, plotter_pkg::STEP_Y: begin
					// the first cycle of an axis is low, so dir is stable before the pulse
					if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (level) begin
						level <= 1'b0;
						timer <= HALF_LOAD;
					end else if (remaining != '0) begin
						level     <= 1'b1;
						timer     <= HALF_LOAD;
						remaining <= remaining - 1'b1;
					end else if ((state == plotter_pkg::STEP_X) && (y_pulses != '0)) begin
						state     <= plotter_pkg::STEP_Y;
						remaining <= y_pulses;
					end else begin
						// last low half is over
						state <= plotter_pkg::IDLE;
					end
				end
				default: state <= plotter_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== design/plotter_pkg.sv ====
`include "plotter_defines.svh"

package plotter_pkg;

	// command opcodes, the fourth encoding is never issued and is ignored
	typedef enum logic [1:0] {
		PEN_UP   = 2'd0,
		PEN_DOWN = 2'd1,
		MOVE     = 2'd2
	} opcode_t;

	// sequencer walks X first, then Y, then returns to IDLE
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		STEP_X = 2'd1,
		STEP_Y = 2'd2
	} seq_state_t;

	// dx and dy are only looked at for a MOVE
	typedef struct packed {
		opcode_t                            op;
		logic signed [`PLOT_MOVE_BITS-1:0]  dx;
		logic signed [`PLOT_MOVE_BITS-1:0]  dy;
	} plot_cmd_t;

	// stepper lines between the sequencer and the tracker
	// a dir bit of 1 moves the pen toward the lower coordinate
	typedef struct packed {
		logic step_x;
		logic dir_x;
		logic step_y;
		logic dir_y;
		logic pen_down;
	} step_bus_t;

	// one pixel write per cycle while wr_en is high
	typedef struct packed {
		logic                              wr_en;
		logic [`PLOT_CANVAS_X_BITS-1:0]    x;
		logic [`PLOT_CANVAS_Y_BITS-1:0]    y;
		logic [`PLOT_INK_BITS-1:0]         ink;
	} pixel_write_t;

endpackage

// ==== include/plotter_defines.svh ====
`ifndef PLOTTER_DEFINES_SVH
`define PLOTTER_DEFINES_SVH

// canvas geometry, 32 columns by 16 rows
`define PLOT_CANVAS_X_BITS 5
`define PLOT_CANVAS_Y_BITS 4

// the tracker keeps a wider position than the canvas
// and the canvas address is just its low bits, so the pen wraps
`define PLOT_POS_BITS 8

// rising step edges needed to move the pen by one pixel
`define PLOT_PULSES_PER_PIXEL 4

// cycles a step pulse stays high, and then the same number low
`define PLOT_PULSE_HALF 2

// width of the signed pixel offsets carried by a move command
`define PLOT_MOVE_BITS 6

// width of one canvas cell
`define PLOT_INK_BITS 8

// byte stored for every pixel the pen touches while down
`define PLOT_INK 8'hff

`endif
